//--- common/sd_axi_pkg.sv
`default_nettype none

package sd_axi_pkg;

    localparam int ddr_data_w = 256;
    localparam int strb_w     = ddr_data_w / 8;
    localparam int addr_w     = 32;
    localparam int id_w       = 8;
    localparam int sample_w   = 16;
    localparam int fifo_depth = 16;

    localparam int lane_w     = $clog2(strb_w);          // byte lane select bits
    localparam int fifo_ptr_w = $clog2(fifo_depth);
    localparam int fifo_cnt_w = $clog2(fifo_depth) + 1;  // holds 0..fifo_depth

    localparam logic [id_w-1:0] axi_wr_id      = 8'd40;
    localparam logic [2:0]      axi_size_32b   = 3'd5;
    localparam logic [1:0]      axi_burst_incr = 2'd1;

    typedef struct packed {
        logic                last;
        logic [sample_w-1:0] data;
    } sample_entry_t;

    typedef struct packed {
        logic [id_w-1:0]   id;
        logic [addr_w-1:0] addr;
        logic [7:0]        len;
        logic [2:0]        size;
        logic [1:0]        burst;
        logic              lock;
        logic [3:0]        cache;
        logic [2:0]        prot;
    } axi_aw_t;

    typedef struct packed {
        logic [ddr_data_w-1:0] data;
        logic [strb_w-1:0]     strb;
        logic                  last;
    } axi_w_t;

    typedef struct packed {
        logic [id_w-1:0] id;
        logic [1:0]      resp;
    } axi_b_t;

    // one single-beat write per sample
    typedef enum logic [1:0] {
        st_addr,
        st_data,
        st_resp,
        st_done
    } wr_state_e;

endpackage

`default_nettype wire

//--- sample_fifo/sample_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module sample_fifo
    import sd_axi_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    input  logic          push,
    input  sample_entry_t entry,
    input  logic          pop,
    output sample_entry_t head,
    output logic          empty,
    output logic          overflow
);

    sample_entry_t mem [fifo_depth];

    logic [fifo_ptr_w-1:0] wr_ptr;
    logic [fifo_ptr_w-1:0] rd_ptr;
    logic [fifo_cnt_w-1:0] count;

    logic full;
    logic wr_en;
    logic rd_en;

    assign full  = (count == fifo_cnt_w'(fifo_depth));
    assign empty = (count == '0);

    assign wr_en = push & ~full;  // no back-pressure, so a full push is lost
    assign rd_en = pop & ~empty;

    // first word falls through
    assign head = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= entry;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
        end else if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_ptr <= '0;
        end else if (rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count <= '0;
        end else begin
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // both or neither
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            overflow <= 1'b0;
        end else if (push && full) begin
            overflow <= 1'b1;  // sticky until reset
        end
    end

endmodule

`default_nettype wire

//--- axi_wr_master/axi_wr_master.sv
`timescale 1ns/10ps
`default_nettype none

module axi_wr_master
    import sd_axi_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic [addr_w-1:0] base_addr,

    input  sample_entry_t     head,
    input  logic              empty,
    output logic              pop,

    output axi_aw_t           aw,
    output logic              aw_valid,
    input  logic              aw_ready,

    output axi_w_t            w,
    output logic              w_valid,
    input  logic              w_ready,

    input  axi_b_t            b,
    input  logic              b_valid,
    output logic              b_ready,

    output logic              done,
    output logic              resp_err
);

    wr_state_e state;
    wr_state_e state_nxt;

    logic [addr_w-1:0] addr_q;
    logic              last_q;   // last flag of the sample in flight

    logic [lane_w-1:0] lane;
    logic              aw_hs;
    logic              w_hs;
    logic              b_hs;

    assign aw_hs = aw_valid & aw_ready;
    assign w_hs  = w_valid & w_ready;
    assign b_hs  = b_valid & b_ready;

    // handshakes gated by state through the valids
    assign aw_valid = (state == st_addr) & ~empty;
    assign w_valid  = (state == st_data) & ~empty;
    assign b_ready  = (state == st_resp);
    assign done     = (state == st_done);
    assign pop      = w_hs;

    assign aw.id    = axi_wr_id;
    assign aw.addr  = addr_q;
    assign aw.len   = 8'd0;           // single beat
    assign aw.size  = axi_size_32b;
    assign aw.burst = axi_burst_incr;
    assign aw.lock  = 1'b0;
    assign aw.cache = 4'd0;
    assign aw.prot  = 3'd0;

    // sample lands at the byte lane of the current address
    assign lane   = addr_q[lane_w-1:0];
    assign w.data = {{(ddr_data_w - sample_w){1'b0}}, head.data} << {lane, 3'b000};
    assign w.strb = {{(strb_w - 2){1'b0}}, 2'b11} << lane;
    assign w.last = 1'b1;

    always_comb begin
        state_nxt = state;
        case (state)
            st_addr: begin
                if (aw_hs) begin
                    state_nxt = st_data;
                end
            end
            st_data: begin
                if (w_hs) begin
                    state_nxt = st_resp;
                end
            end
            st_resp: begin
                if (b_hs) begin
                    state_nxt = last_q ? st_done : st_addr;
                end
            end
            st_done: begin
                state_nxt = st_done;  // held until reset
            end
            default: begin
                state_nxt = st_addr;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_addr;
        end else begin
            state <= state_nxt;
        end
    end

    // base is reloaded on every reset cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            addr_q <= base_addr;
        end else if (w_hs) begin
            addr_q <= addr_q + addr_w'(2);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            last_q <= 1'b0;
        end else if (w_hs) begin
            last_q <= head.last;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            resp_err <= 1'b0;
        end else if (b_hs && (b.resp != 2'b00)) begin
            resp_err <= 1'b1;  // sticky, any non-OKAY
        end
    end

endmodule

`default_nettype wire

//--- design/sd_axi_top.sv
`timescale 1ns/10ps
`default_nettype none

module sd_axi_top
    import sd_axi_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic [addr_w-1:0] base_addr,

    // sample stream, no back-pressure
    input  logic              push,
    input  sample_entry_t     entry,

    output axi_aw_t           aw,
    output logic              aw_valid,
    input  logic              aw_ready,

    output axi_w_t            w,
    output logic              w_valid,
    input  logic              w_ready,

    input  axi_b_t            b,
    input  logic              b_valid,
    output logic              b_ready,

    output logic              done,
    output logic              resp_err,
    output logic              overflow
);

    sample_entry_t fifo_head;
    logic          fifo_empty;
    logic          fifo_pop;

    sample_fifo sample_fifo_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .push     (push),
        .entry    (entry),
        .pop      (fifo_pop),
        .head     (fifo_head),
        .empty    (fifo_empty),
        .overflow (overflow)
    );

    axi_wr_master axi_wr_master_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .base_addr (base_addr),
        .head      (fifo_head),
        .empty     (fifo_empty),
        .pop       (fifo_pop),
        .aw        (aw),
        .aw_valid  (aw_valid),
        .aw_ready  (aw_ready),
        .w         (w),
        .w_valid   (w_valid),
        .w_ready   (w_ready),
        .b         (b),
        .b_valid   (b_valid),
        .b_ready   (b_ready),
        .done      (done),
        .resp_err  (resp_err)
    );

endmodule

`default_nettype wire

//--- test/sd_axi_asserts.sv
`timescale 1ns/10ps
`default_nettype none

module sd_axi_asserts
    import sd_axi_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    pop,
    input  axi_aw_t aw,
    input  logic    aw_valid,
    input  logic    aw_ready,
    input  axi_w_t  w,
    input  logic    w_valid,
    input  logic    w_ready,
    input  axi_b_t  b,
    input  logic    b_valid,
    input  logic    b_ready,
    input  logic    done,
    input  logic    resp_err
);

    int fail_cnt = 0;

    logic       aw_hs;
    logic       w_hs;
    logic       b_hs;
    logic [1:0] phase_q;  // 0 idle, 1 after AW, 2 after W

    assign aw_hs = aw_valid & aw_ready;
    assign w_hs  = w_valid & w_ready;
    assign b_hs  = b_valid & b_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phase_q <= 2'd0;
        end else if (aw_hs) begin
            phase_q <= 2'd1;
        end else if (w_hs) begin
            phase_q <= 2'd2;
        end else if (b_hs) begin
            phase_q <= 2'd0;
        end
    end

    aw_fields_a: assert property (@(posedge clk) disable iff (!rst_n)
        aw_valid |-> (aw.id == 8'd40 && aw.len == 8'd0 && aw.size == 3'd5 && aw.burst == 2'd1
                      && !aw.lock && aw.cache == 4'd0 && aw.prot == 3'd0))
        else begin
            $error("AW carries a wrong fixed field");
            fail_cnt++;
        end

    w_last_a: assert property (@(posedge clk) disable iff (!rst_n)
        w_valid |-> w.last)
        else begin
            $error("W beat without last");
            fail_cnt++;
        end

    aw_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
        (aw_valid && !aw_ready) |=> (aw_valid && $stable(aw)))
        else begin
            $error("AW changed while stalled");
            fail_cnt++;
        end

    w_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
        (w_valid && !w_ready) |=> (w_valid && $stable(w)))
        else begin
            $error("W changed while stalled");
            fail_cnt++;
        end

    pop_a: assert property (@(posedge clk) disable iff (!rst_n)
        pop |-> w_hs)
        else begin
            $error("FIFO pop without a W handshake");
            fail_cnt++;
        end

    order_a: assert property (@(posedge clk) disable iff (!rst_n)
        (!aw_hs || phase_q == 2'd0) && (!w_hs || phase_q == 2'd1) && (!b_hs || phase_q == 2'd2))
        else begin
            $error("AW, W and B out of order");
            fail_cnt++;
        end

    done_quiet_a: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> (!aw_valid && !w_valid))
        else begin
            $error("request issued after done");
            fail_cnt++;
        end

    err_set_a: assert property (@(posedge clk) disable iff (!rst_n)
        (b_hs && b.resp != 2'b00) |=> resp_err)
        else begin
            $error("bad response did not set resp_err");
            fail_cnt++;
        end

    err_sticky_a: assert property (@(posedge clk) disable iff (!rst_n)
        resp_err |=> resp_err)
        else begin
            $error("resp_err dropped before reset");
            fail_cnt++;
        end

endmodule

bind axi_wr_master sd_axi_asserts axi_asserts_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .pop      (pop),
    .aw       (aw),
    .aw_valid (aw_valid),
    .aw_ready (aw_ready),
    .w        (w),
    .w_valid  (w_valid),
    .w_ready  (w_ready),
    .b        (b),
    .b_valid  (b_valid),
    .b_ready  (b_ready),
    .done     (done),
    .resp_err (resp_err)
);

`default_nettype wire

//--- test/tb_sd_axi_top.sv
`timescale 1ns/10ps
`default_nettype none

module tb_sd_axi_top
    import sd_axi_pkg::*;
();

    logic              clk;
    logic              rst_n;
    logic [addr_w-1:0] base_addr;
    logic              push;
    sample_entry_t     entry;
    axi_aw_t           aw;
    logic              aw_valid;
    logic              aw_ready;
    axi_w_t            w;
    logic              w_valid;
    logic              w_ready;
    axi_b_t            b;
    logic              b_valid;
    logic              b_ready;
    logic              done;
    logic              resp_err;
    logic              overflow;

    logic [7:0]  ddr_mem [logic [31:0]];  // byte addressed slave memory
    logic [15:0] exp_data [$];            // samples expected in memory, in order
    logic [31:0] aw_addr_q;
    logic [31:0] stall_state;
    logic [31:0] data_state;
    logic [4:0]  mon_lane;
    int          aw_cnt;
    int          w_cnt;
    int          b_cnt;
    int          pushed;
    int          err_idx;
    int          n_checks;
    int          n_errors;
    int          n_timeouts;
    bit          b_pending;
    bit          hold_aw;
    bit          ovf_expected;

    sd_axi_top sd_axi_top_i (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic expect_true(input bit cond, input string msg);
        n_checks++;
        assert (cond) else begin
            $display("CHECK FAILED at %0t: %s", $time, msg);
            n_errors++;
        end
    endtask

    task automatic print_counts();
        $display("checks %0d, check errors %0d, timeouts %0d, assertion errors %0d",
                 n_checks, n_errors, n_timeouts,
                 sd_axi_top_i.axi_wr_master_i.axi_asserts_i.fail_cnt);
    endtask

    task automatic report_timeout(input string why);
        $display("timeout while waiting for %s at %0t", why, $time);
        n_timeouts++;
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic apply_reset(input logic [31:0] base);
        rst_n = 1'b0;
        base_addr = base;
        push = 1'b0;
        repeat (5) next_cycle();
        aw_cnt = 0;
        w_cnt = 0;
        b_cnt = 0;
        pushed = 0;
        b_pending = 1'b0;
        hold_aw = 1'b0;
        ovf_expected = 1'b0;
        exp_data.delete();
        ddr_mem.delete();
        rst_n = 1'b1;
    endtask

    task automatic push_sample(input logic [15:0] data, input logic last, input bit keep);
        push = 1'b1;
        entry.data = data;
        entry.last = last;
        if (keep) begin
            exp_data.push_back(data);
            pushed++;
        end
        next_cycle();
        push = 1'b0;
    endtask

    task automatic wait_room();
        int cycles;
        cycles = 0;
        while (pushed - w_cnt >= 8 && cycles < 500) begin
            next_cycle();
            cycles++;
        end
        if (pushed - w_cnt >= 8) report_timeout("FIFO room");
    endtask

    task automatic wait_responses(input int n);
        int cycles;
        cycles = 0;
        while (b_cnt < n && cycles < 3000) begin
            next_cycle();
            cycles++;
        end
        if (b_cnt < n) report_timeout("write responses");
    endtask

    task automatic wait_done();
        int cycles;
        cycles = 0;
        while (!done && cycles < 100) begin
            next_cycle();
            cycles++;
        end
        if (!done) report_timeout("done");
    endtask

    task automatic check_memory(input int n);
        logic [31:0] a;
        for (int k = 0; k < n; k++) begin
            a = base_addr + 32'(2 * k);
            if (ddr_mem.exists(a) && ddr_mem.exists(a + 1)) begin
                expect_true({ddr_mem[a + 1], ddr_mem[a]} == exp_data[k],
                            $sformatf("memory at %h holds %h%h", a, ddr_mem[a + 1], ddr_mem[a]));
            end else begin
                expect_true(1'b0, $sformatf("memory at %h never written", a));
            end
        end
    endtask

    // bus monitor, sampled mid-cycle where the DUT outputs are settled
    always @(negedge clk) begin
        if (rst_n) begin
            expect_true(b_ready == b_pending, "b_ready outside the response phase");
            if (aw_valid && aw_ready) begin
                expect_true(aw.addr == base_addr + 2 * aw_cnt, $sformatf("AW address %h", aw.addr));
                aw_addr_q = aw.addr;
                aw_cnt++;
            end
            if (w_valid && w_ready) begin
                mon_lane = 5'(base_addr + 32'(2 * w_cnt));
                expect_true(w.strb == (32'h3 << mon_lane), $sformatf("W strobe %h", w.strb));
                if (w_cnt < exp_data.size()) begin
                    expect_true(w.data[8 * mon_lane +: 16] == exp_data[w_cnt],
                                $sformatf("W data for sample %0d", w_cnt));
                end
                for (int i = 0; i < 32; i++) begin
                    if (w.strb[i]) begin
                        ddr_mem[{aw_addr_q[31:5], 5'b00000} + 32'(i)] = w.data[8 * i +: 8];
                    end
                end
                w_cnt++;
                b_pending = 1'b1;
            end
            if (b_valid && b_ready) begin
                expect_true(resp_err == (b_cnt > err_idx), $sformatf("resp_err at B %0d", b_cnt));
                b_cnt++;
                b_pending = 1'b0;
            end
            if (!ovf_expected) expect_true(!overflow, "overflow without a full FIFO");
        end
    end

    // slave side with random stalls
    always @(posedge clk) begin
        #1;
        stall_state = xorshift32(stall_state);
        if (!rst_n) begin
            aw_ready = 1'b0;
            w_ready = 1'b0;
            b_valid = 1'b0;
        end else begin
            aw_ready = !hold_aw && (stall_state[1:0] != 2'b00);
            w_ready = stall_state[3:2] != 2'b00;
            b_valid = b_pending && (b_valid || stall_state[4]);
        end
        b.id = 8'd40;
        b.resp = (b_cnt == err_idx) ? 2'b10 : 2'b00;  // SLVERR for the chosen write
    end

    initial begin
        rst_n = 1'b0;
        base_addr = '0;
        push = 1'b0;
        entry = '0;
        aw_ready = 1'b0;
        w_ready = 1'b0;
        b = '0;
        b_valid = 1'b0;
        stall_state = 32'h93b40805;
        data_state = 32'h93b40805;
        n_checks = 0;
        n_errors = 0;
        n_timeouts = 0;

        // 40 samples with one error response
        err_idx = 17;
        apply_reset(32'h1000_0010);
        for (int k = 0; k < 40; k++) begin
            wait_room();
            data_state = xorshift32(data_state);
            push_sample(data_state[15:0], k == 39, 1'b1);
        end
        wait_responses(40);
        wait_done();
        expect_true(resp_err, "resp_err after the error response");
        for (int k = 0; k < 3; k++) begin
            data_state = xorshift32(data_state);
            push_sample(data_state[15:0], 1'b0, 1'b0);
        end
        for (int k = 0; k < 20; k++) begin
            expect_true(done && !aw_valid, "AW after the last sample");
            next_cycle();
        end
        expect_true(aw_cnt == 40, $sformatf("%0d AW handshakes", aw_cnt));
        check_memory(40);

        // overflow against a stalled address channel
        err_idx = 1000;
        apply_reset(32'h2000_0040);
        expect_true(!done && !resp_err, "flags after reset");
        hold_aw = 1'b1;
        for (int k = 0; k < 20; k++) begin
            if (k == 16) ovf_expected = 1'b1;
            data_state = xorshift32(data_state);
            push_sample(data_state[15:0], k == 15, k < 16);
        end
        next_cycle();
        expect_true(overflow, "overflow after 20 pushes");
        hold_aw = 1'b0;
        wait_responses(16);
        wait_done();
        expect_true(w_cnt == 16 && !resp_err, $sformatf("%0d writes after overflow", w_cnt));
        check_memory(16);
        expect_true(!ddr_mem.exists(base_addr + 32), "dropped sample reached memory");

        print_counts();
        if (n_errors == 0 && n_timeouts == 0
            && sd_axi_top_i.axi_wr_master_i.axi_asserts_i.fail_cnt == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sd_axi_wr.f
common/sd_axi_pkg.sv
sample_fifo/sample_fifo.sv
axi_wr_master/axi_wr_master.sv
design/sd_axi_top.sv
test/sd_axi_asserts.sv
test/tb_sd_axi_top.sv

//--- Makefile
SIM      := verilator
SIMFLAGS := --binary --timing --assert -j 0
TOP      := tb_sd_axi_top
FILELIST := sd_axi_wr.f
OBJDIR   := obj_dir
BIN      := $(OBJDIR)/V$(TOP)
LOG      := sim.log
RUNFLAGS := +verilator+error+limit+1000
FAIL_MSG := Verification failed
PASS_MSG := Verification passed

SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(SIMFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) $(RUNFLAGS) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)
